/* design/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// ======================================================================
// load/store unit sizes
// ======================================================================

// data and address width, one rv32 word.
`define LSU_XLEN        32

// byte lanes per word, fixed by the rv32 byte layout.
`define LSU_LANES       4

// log2 of the word count of the private data memory.
`define LSU_DEPTH_LOG2  8

// number of words per bank, derived.
`define LSU_DEPTH       (1 << `LSU_DEPTH_LOG2)

// word index sits just above the two byte-offset bits.
`define LSU_IDX_LO      2
`define LSU_IDX_HI      (`LSU_DEPTH_LOG2 + 1)

`endif

/* design/lsu_pkg.sv */
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

    // ==================================================================
    // operations
    // ==================================================================

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,  // idle slot.
        OP_LB   = 4'd1,  // load byte, sign extended.
        OP_LBU  = 4'd2,  // load byte, zero extended.
        OP_LH   = 4'd3,  // load halfword, sign extended.
        OP_LHU  = 4'd4,  // load halfword, zero extended.
        OP_LW   = 4'd5,  // load word.
        OP_SB   = 4'd6,  // store byte.
        OP_SH   = 4'd7,  // store halfword.
        OP_SW   = 4'd8   // store word.
    } mem_op_e;

    // ==================================================================
    // records passed between blocks
    // ==================================================================

    // request as issued by the core, one per clock.
    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        logic [`LSU_XLEN-1:0]  addr;   // byte address.
        logic [`LSU_XLEN-1:0]  wdata;  // raw store data, low bits used.
    } lsu_req_t;

    // command for one byte bank.
    typedef struct packed {
        logic                        we;
        logic [`LSU_DEPTH_LOG2-1:0]  windex;
        logic [7:0]                  wbyte;
        logic [`LSU_DEPTH_LOG2-1:0]  rindex;
    } lane_wr_t;

    // request in flight, lines up with the bank read data.
    typedef struct packed {
        logic     valid;
        mem_op_e  op;
        logic [1:0] offset;      // byte offset within the word.
        logic     misaligned;
    } pend_t;

endpackage

`default_nettype wire

/* design/lsu_store_align.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_store_align import lsu_pkg::*; (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire lsu_req_t                          req,
    output lane_wr_t [`LSU_LANES-1:0]              lane_wr,
    output pend_t                                  pend
);

    // ==================================================================
    // decode
    // ==================================================================

    logic                       is_store;    // sb, sh or sw.
    logic                       is_half;     // lh, lhu or sh.
    logic                       is_word;     // lw or sw.
    logic [1:0]                 offset;
    logic                       misaligned;
    logic [`LSU_LANES-1:0]      lane_en;     // lanes touched by the store width.
    logic [`LSU_LANES-1:0]      lane_we;     // final per-lane write enable.
    logic [`LSU_XLEN-1:0]       wdata_rep;   // store data spread over lanes.
    logic [`LSU_DEPTH_LOG2-1:0] windex;

    assign offset = req.addr[1:0];
    assign windex = req.addr[`LSU_IDX_HI:`LSU_IDX_LO];  // upper bits wrap.

    always_comb begin
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (req.op)
            OP_LH, OP_LHU: is_half = 1'b1;
            OP_LW:         is_word = 1'b1;
            OP_SB:         is_store = 1'b1;
            OP_SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            OP_SW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: ;  // byte loads and idle need nothing.
        endcase
    end

    // halfword on odd byte, word off a word boundary.
    assign misaligned = (is_half & offset[0]) | (is_word & (offset != 2'b00));

    // ==================================================================
    // lane enables and data replication
    // ==================================================================

    always_comb begin
        lane_en   = '0;
        wdata_rep = req.wdata;
        case (req.op)
            OP_SB: begin
                lane_en   = 4'b0001 << offset;
                wdata_rep = {4{req.wdata[7:0]}};  // same byte on every lane.
            end
            OP_SH: begin
                lane_en   = 4'b0011 << offset;   // offset 0 or 2 when legal.
                wdata_rep = {2{req.wdata[15:0]}};
            end
            OP_SW: lane_en = 4'b1111;
            default: ;
        endcase
    end

    // a misaligned store writes nothing.
    assign lane_we = lane_en & {`LSU_LANES{req.valid & is_store & ~misaligned}};

    // all lanes read the same word every cycle.
    always_comb begin
        for (int i = 0; i < `LSU_LANES; i++) begin
            lane_wr[i].we     = lane_we[i];
            lane_wr[i].windex = windex;
            lane_wr[i].wbyte  = wdata_rep[8*i +: 8];
            lane_wr[i].rindex = windex;
        end
    end

    // ==================================================================
    // pending record, lines up with bank read data
    // ==================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend <= '0;
        end else begin
            pend.valid      <= req.valid;
            pend.op         <= req.op;
            pend.offset     <= offset;
            pend.misaligned <= misaligned;
        end
    end

    // no idle opcode on a valid slot.
    a_op_valid: assert property (@(posedge clk) disable iff (!arst_n)
        req.valid |-> req.op != OP_NONE);

    // store width bounds the number of written lanes.
    a_lane_count: assert property (@(posedge clk) disable iff (!arst_n)
        $countones(lane_we) <= ((req.op == OP_SW) ? 4 :
                                (req.op == OP_SH) ? 2 :
                                (req.op == OP_SB) ? 1 : 0));

endmodule

`default_nettype wire

/* design/lsu_byte_bank.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_byte_bank import lsu_pkg::*; (
    input  wire logic      clk,
    input  wire lane_wr_t  lane_wr,
    output logic [7:0]     lane_rdata
);

    // ==================================================================
    // storage, one byte lane of the data memory
    // ==================================================================

    logic [7:0] mem [`LSU_DEPTH];  // contents are not reset.

    // masked write and registered read share the edge.
    // a store reads its own word and gets old data,
    // the extractor drops the read data of a store.
    always_ff @(posedge clk) begin
        if (lane_wr.we) begin
            mem[lane_wr.windex] <= lane_wr.wbyte;  // lane selected by store mask.
        end
        lane_rdata <= mem[lane_wr.rindex];         // read every cycle.
    end

endmodule

`default_nettype wire

/* design/lsu_load_extract.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_load_extract import lsu_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire pend_t                         pend,
    input  wire logic [`LSU_LANES-1:0][7:0]    lane_rdata,
    output logic                               done,
    output logic                               err,
    output logic [`LSU_XLEN-1:0]               rdata
);

    // ==================================================================
    // lane merge and rotate
    // ==================================================================

    logic [`LSU_XLEN-1:0] merged;    // lane 0 is the low byte.
    logic [`LSU_XLEN-1:0] shifted;   // addressed byte moved to bit 0.
    logic [`LSU_XLEN-1:0] rdata_d;
    logic                 done_d;
    logic                 err_d;

    assign merged  = lane_rdata;                         // packed lanes, lane 0 low.
    assign shifted = merged >> {pend.offset, 3'b000};    // eight bits per offset step.

    // ==================================================================
    // extension and completion
    // ==================================================================

    always_comb begin
        done_d  = 1'b0;
        err_d   = 1'b0;
        rdata_d = '0;
        if (pend.valid) begin
            if (pend.misaligned) begin
                err_d = 1'b1;        // trusted from the aligner.
            end else begin
                done_d = 1'b1;
                case (pend.op)
                    OP_LB:  rdata_d = {{24{shifted[7]}}, shifted[7:0]};
                    OP_LBU: rdata_d = {24'h0, shifted[7:0]};
                    OP_LH:  rdata_d = {{16{shifted[15]}}, shifted[15:0]};
                    OP_LHU: rdata_d = {16'h0, shifted[15:0]};
                    OP_LW:  rdata_d = shifted;          // offset is zero here.
                    default: rdata_d = '0;              // stores return zero.
                endcase
            end
        end
    end

    // response registers, one pulse per request.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done  <= 1'b0;
            err   <= 1'b0;
            rdata <= '0;
        end else begin
            done  <= done_d;
            err   <= err_d;
            rdata <= rdata_d;
        end
    end

    // a request completes one way only.
    a_done_err: assert property (@(posedge clk) disable iff (!arst_n)
        !(done && err));

endmodule

`default_nettype wire

/* design/lsu_top.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_top import lsu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire lsu_req_t          req,
    output logic                   done,
    output logic                   err,
    output logic [`LSU_XLEN-1:0]   rdata
);

    // ==================================================================
    // internal wiring
    // ==================================================================

    lane_wr_t [`LSU_LANES-1:0]       lane_wr;     // aligner to banks.
    logic     [`LSU_LANES-1:0][7:0]  lane_rdata;  // banks to extractor.
    pend_t                           pend;        // aligner to extractor.

    // request decode and write side.
    lsu_store_align lsu_store_align_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .lane_wr (lane_wr),
        .pend    (pend)
    );

    // one bank per byte lane.
    for (genvar i = 0; i < `LSU_LANES; i++) begin : g_bank
        lsu_byte_bank lsu_byte_bank_i (
            .clk        (clk),
            .lane_wr    (lane_wr[i]),
            .lane_rdata (lane_rdata[i])
        );
    end

    // read side and completion.
    lsu_load_extract lsu_load_extract_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .pend       (pend),
        .lane_rdata (lane_rdata),
        .done       (done),
        .err        (err),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

/* tb/lsu_checker.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_checker import lsu_pkg::*; (
    input wire logic                 clk,
    input wire logic                 arst_n,
    input wire lsu_req_t             req,
    input wire logic                 done,
    input wire logic                 err,
    input wire logic [`LSU_XLEN-1:0] rdata
);

    typedef struct packed {
        logic                 done;
        logic                 err;
        logic [`LSU_XLEN-1:0] rdata;
    } resp_t;

    logic [7:0] shadow [`LSU_DEPTH*`LSU_LANES];  // byte image of the data memory.
    resp_t      exp_now  = '0;                   // due for the request just sampled.
    resp_t      exp_prev = '0;                   // due on the outputs now.
    logic       armed    = 1'b0;                 // no expectation before the first edge.
    int         errors       = 0;
    int         checks       = 0;
    int         test_errors  = 0;
    int         test_checks  = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;

    // ======================================================================
    // reference model
    // ======================================================================

    function automatic logic [`LSU_XLEN-1:0] shadow_word(input logic [`LSU_XLEN-1:0] addr);
        logic [`LSU_DEPTH_LOG2-1:0] w;
        w = addr[`LSU_IDX_HI:`LSU_IDX_LO];  // upper bits wrap.
        return {shadow[{w, 2'd3}], shadow[{w, 2'd2}], shadow[{w, 2'd1}], shadow[{w, 2'd0}]};
    endfunction

    function automatic resp_t expected_result(input logic valid, input mem_op_e op,
                                              input logic [1:0] off,
                                              input logic [`LSU_XLEN-1:0] word);
        resp_t                r;
        logic [`LSU_XLEN-1:0] moved;
        logic                 mis;
        r     = '0;
        moved = word >> (8 * off);  // addressed byte lands at bit 0.
        case (op)
            OP_LH, OP_LHU, OP_SH: mis = off[0];
            OP_LW, OP_SW:         mis = (off != 2'd0);
            default:              mis = 1'b0;
        endcase
        if (valid && mis) begin
            r.err = 1'b1;  // rdata stays zero.
        end else if (valid) begin
            r.done = 1'b1;
            case (op)
                OP_LB:   r.rdata = {{24{moved[7]}}, moved[7:0]};
                OP_LBU:  r.rdata = {24'h0, moved[7:0]};
                OP_LH:   r.rdata = {{16{moved[15]}}, moved[15:0]};
                OP_LHU:  r.rdata = {16'h0, moved[15:0]};
                OP_LW:   r.rdata = word;
                default: r.rdata = '0;  // stores.
            endcase
        end
        return r;
    endfunction

    // low bytes of wdata go to consecutive byte addresses.
    task automatic apply_store(input mem_op_e op, input logic [`LSU_XLEN-1:0] addr,
                               input logic [`LSU_XLEN-1:0] wdata);
        logic [`LSU_IDX_HI:0] b;
        int                   n;
        b = addr[`LSU_IDX_HI:0];
        case (op)
            OP_SB:   n = 1;
            OP_SH:   n = 2;
            OP_SW:   n = 4;
            default: n = 0;
        endcase
        for (int k = 0; k < n; k++) shadow[b + k] = wdata[8*k +: 8];
    endtask

    // ======================================================================
    // sampling and comparison
    // ======================================================================

    // under reset the outputs are due to hold their reset values.
    always @(posedge clk) begin
        exp_prev = exp_now;
        if (arst_n) begin
            exp_now = expected_result(req.valid, req.op, req.addr[1:0],
                                      shadow_word(req.addr));
            if (exp_now.done) apply_store(req.op, req.addr, req.wdata);  // aligned only.
        end else begin
            exp_now = '0;  // nothing is accepted under reset.
        end
        armed = 1'b1;
    end

    task automatic compare_value(input string name, input logic [`LSU_XLEN-1:0] expected,
                                 input logic [`LSU_XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s expected %h actual %h", $time, name, expected,
                     actual);
            errors++;
            test_errors++;
        end
    endtask

    // outputs are settled on the falling edge.
    always @(negedge clk) begin
        if (armed) begin
            checks++;
            test_checks++;
            compare_value("done", {{(`LSU_XLEN-1){1'b0}}, exp_prev.done},
                          {{(`LSU_XLEN-1){1'b0}}, done});
            compare_value("err", {{(`LSU_XLEN-1){1'b0}}, exp_prev.err},
                          {{(`LSU_XLEN-1){1'b0}}, err});
            compare_value("rdata", exp_prev.rdata, rdata);
        end
    end

    // ======================================================================
    // reporting
    // ======================================================================

    task automatic finish_test(input string name);
        if (test_checks == 0) begin
            $display("no responses were checked during test %s", name);
            test_errors++;
            errors++;
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok, %0d cycles checked", name, test_checks);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches in %0d cycles", name, test_errors, test_checks);
        end
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic report_counts();
        $display("summary: %0d tests ok, %0d tests with errors, %0d cycles, %0d mismatches",
                 tests_passed, tests_failed, checks, errors);
    endtask

endmodule

`default_nettype wire

/* tb/lsu_tb.sv */
`default_nettype none

`include "lsu_defs.svh"

module lsu_tb import lsu_pkg::*; ();

    // ======================================================================
    // run sizes
    // ======================================================================

    localparam int PERIOD     = 8;
    localparam int RESET_CYC  = 10;
    localparam int N_FILL     = 64;                     // preloaded words, also the random window.
    localparam int N_RANDOM   = 400;
    localparam int N_DIRECTED = 2*N_FILL + 24 + 26 + 14; // round trip, partial, extension, misaligned.
    localparam int TIMEOUT    = (2*(N_DIRECTED + N_RANDOM) + RESET_CYC) * PERIOD;

    logic                 clk;
    logic                 arst_n;
    lsu_req_t             req;
    logic                 done;
    logic                 err;
    logic [`LSU_XLEN-1:0] rdata;
    integer               seed = 32'h33dedcbd;

    always #(PERIOD/2) clk = ~clk;

    lsu_top lsu_top_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .done   (done),
        .err    (err),
        .rdata  (rdata)
    );

    lsu_checker lsu_checker_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .done   (done),
        .err    (err),
        .rdata  (rdata)
    );

    // ======================================================================
    // stimulus helpers
    // ======================================================================

    // one request, set up on the falling edge.
    task automatic issue(input mem_op_e op, input logic [`LSU_XLEN-1:0] addr,
                         input logic [`LSU_XLEN-1:0] wdata);
        @(negedge clk);
        req.valid = 1'b1;
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
    endtask

    // idle the bus and let the last responses get compared.
    task automatic close_test(input string name);
        @(negedge clk);
        req = '0;
        @(negedge clk);  // last response compared here.
        @(posedge clk);
        lsu_checker_i.finish_test(name);
    endtask

    // every address bit changes the pattern.
    function automatic logic [`LSU_XLEN-1:0] fill_word(input logic [`LSU_XLEN-1:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        logic [`LSU_XLEN-1:0] base;
        logic [`LSU_XLEN-1:0] r;
        mem_op_e              op;
        clk    = 1'b0;
        arst_n = 1'b0;
        req    = '0;
        repeat (RESET_CYC) @(negedge clk);
        arst_n = 1'b1;

        repeat (6) @(negedge clk);  // outputs must stay quiet.
        close_test("reset");

        // fill the window, then read every word back.
        for (int i = 0; i < N_FILL; i++) issue(OP_SW, 4*i, fill_word(4*i));
        for (int i = 0; i < N_FILL; i++) issue(OP_LW, 4*i, '0);
        close_test("word round trip");

        for (int w = 5; w < 7; w++) begin
            base = 4*w;
            for (int k = 0; k < 4; k++) begin
                issue(OP_SB, base + k, $random(seed));
                issue(OP_LW, base, '0);  // load right behind the store.
            end
            for (int k = 0; k < 4; k += 2) begin
                issue(OP_SH, base + k, $random(seed));
                issue(OP_LW, base, '0);
            end
        end
        close_test("partial stores");

        // bytes and halfwords with the top bit set and clear.
        for (int p = 0; p < 2; p++) begin
            base = 4*(9 + p);
            issue(OP_SW, base, (p == 0) ? 32'h807fff01 : 32'h7f8001ff);
            for (int k = 0; k < 4; k++) begin
                issue(OP_LB, base + k, '0);
                issue(OP_LBU, base + k, '0);
            end
            for (int k = 0; k < 4; k += 2) begin
                issue(OP_LH, base + k, '0);
                issue(OP_LHU, base + k, '0);
            end
        end
        close_test("extension");

        base = 4*12;
        issue(OP_SW, base, 32'h5a5ac3c3);
        for (int k = 1; k < 4; k += 2) begin
            issue(OP_SH, base + k, 32'hffffffff);
            issue(OP_LH, base + k, '0);
            issue(OP_LHU, base + k, '0);
        end
        for (int k = 1; k < 4; k++) begin
            issue(OP_SW, base + k, 32'hffffffff);
            issue(OP_LW, base + k, '0);
        end
        issue(OP_LW, base, '0);  // word must be untouched.
        close_test("misalignment");

        // upper address bits are random to exercise the wrap.
        for (int i = 0; i < N_RANDOM; i++) begin
            r  = $random(seed);
            op = mem_op_e'(4'(1 + ({$random(seed)} % 8)));
            issue(op, {r[31:10], 2'b00, r[7:0]}, $random(seed));
        end
        close_test("random stream");

        lsu_checker_i.report_counts();
        if (lsu_checker_i.errors == 0 && lsu_checker_i.tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog, generous bound from the request count.
    initial begin
        #(TIMEOUT);
        $display("timeout: the run was still going after %0d time units", TIMEOUT);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
design/lsu_pkg.sv
design/lsu_store_align.sv
design/lsu_byte_bank.sv
design/lsu_load_extract.sv
design/lsu_top.sv
tb/lsu_checker.sv
tb/lsu_tb.sv

/* Makefile */
# Verilator build and run of the load/store unit testbench.

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
